//--- vlog.f
vfdsu_pkg.sv
vfdsu_op_classify.sv
vfdsu_special_detect.sv
vfdsu_nan_select.sv
vfdsu_expnt_round.sv
vfdsu_ex2_pipe.sv
vfdsu_prepare.sv
tb_clk_gen.sv
tb_vfdsu_prepare.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_vfdsu_prepare
FLIST = vlog.f
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD)

//--- tb_vfdsu_prepare.sv
// self-checking testbench for vfdsu_prepare, one op driven per load cycle
// expected values come from a behavioral model clocked on the same edges
`timescale 1ns/1ps

module tb_vfdsu_prepare
  import vfdsu_pkg::*;
();

  // 392 directed + 256 rounding loads, 200 random loads with up to 3 holds each, plus reset
  localparam int MAX_CYCLES = 2000;

  logic        ex1_pipe_clk;
  logic        cpurst_b;
  fp_word_t    ex1_src0;
  fp_word_t    ex1_src1;
  logic        ex1_div;
  logic        ex1_sqrt;
  logic        ex1_double;
  logic        ex1_scalar;
  rm_t         ex1_static_rm;
  rm_t         vfpu_yy_xx_rm;
  logic        vfpu_yy_xx_dqnan;
  logic        ex1_pipedown;
  ex2_result_t ex2_result;
  ex2_result_t exp_result;
  fp_word_t    op_a;
  fp_word_t    op_b;
  logic [31:0] rnd;
  int          seed = 44715;
  int          cycle_cnt = 0;
  int          flag_errs = 0;
  int          expnt_errs = 0;
  int          nan_errs = 0;

  tb_clk_gen u_clk (
    .ex1_pipe_clk (ex1_pipe_clk),
    .cpurst_b     (cpurst_b)
  );

  vfdsu_prepare dut (
    .ex1_pipe_clk     (ex1_pipe_clk),
    .cpurst_b         (cpurst_b),
    .ex1_src0         (ex1_src0),
    .ex1_src1         (ex1_src1),
    .ex1_div          (ex1_div),
    .ex1_sqrt         (ex1_sqrt),
    .ex1_double       (ex1_double),
    .ex1_scalar       (ex1_scalar),
    .ex1_static_rm    (ex1_static_rm),
    .vfpu_yy_xx_rm    (vfpu_yy_xx_rm),
    .vfpu_yy_xx_dqnan (vfpu_yy_xx_dqnan),
    .ex1_pipedown     (ex1_pipedown),
    .ex2_result       (ex2_result)
  );

  // IEEE operand class; unboxed scalar single is a positive-payload NaN
  function automatic op_class_t classify_ref(fp_word_t w, ex1_ctrl_t c);
    op_class_t   r;
    logic [10:0] e;
    logic [51:0] f;
    logic        emax;
    logic        ezero;
    logic        qbit;
    r = '0;
    if (c.dbl)
    begin
      r.sign = w[63];
      e      = w[62:52];
      f      = w[51:0];
      emax   = (e == 11'h7ff);
      qbit   = w[51];
    end
    else
    begin
      r.sign = w[31];
      e      = {3'b0, w[30:23]};
      f      = {29'b0, w[22:0]};
      emax   = (w[30:23] == 8'hff);
      qbit   = w[22];
    end
    ezero       = (e == 11'd0);
    r.cnan      = c.scalar && !c.dbl && (w[63:32] != 32'hffff_ffff);
    r.expnt_max = emax;
    r.expnt     = {2'b0, e};
    if (r.cnan)
    begin
      r.qnan = 1'b1;
    end
    else
    begin
      r.payload = w[51:0];
      r.zero    = ezero && (f == '0);
      r.inf     = emax && (f == '0);
      r.norm    = !emax && !(ezero && (f == '0));
      r.snan    = emax && (f != '0) && !qbit;
      r.qnan    = emax && qbit;
    end
    return r;
  endfunction

  function automatic ex2_result_t ref_prepare(fp_word_t s0, fp_word_t s1, ex1_ctrl_t c,
                                              rm_t srm, rm_t drm, logic dq);
    op_class_t   a;
    op_class_t   b;
    ex2_result_t r;
    logic        dflt;
    a = classify_ref(s0, c);
    b = classify_ref(s1, c);
    r = '0;
    r.div         = c.div;
    r.sqrt        = c.sqrt;
    r.dbl         = c.dbl;
    r.op0_norm    = a.norm;
    r.op1_norm    = b.norm;
    r.expnt_add0  = a.expnt;
    r.result_sign = c.div ? (a.sign ^ b.sign) : a.sign;
    if (c.div)
    begin
      r.nv          = a.snan | b.snan | (a.zero & b.zero) | (a.inf & b.inf);
      r.dz          = b.zero & a.norm;
      r.result_zero = (a.zero & b.norm) | ((a.zero | a.norm) & b.inf);
      // inf/inf is invalid rather than inf
      r.result_inf  = (a.inf & (b.zero | b.norm)) | r.dz;
      r.result_qnan = a.qnan | b.qnan | r.nv;
      dflt          = (a.zero & b.zero) | (a.inf & b.inf);
      r.expnt_add1  = b.expnt;
    end
    else
    begin
      r.nv          = a.snan | (a.sign & (a.norm | a.inf));
      r.result_zero = a.zero;
      r.result_inf  = a.inf & !a.sign;
      r.result_qnan = a.qnan | r.nv;
      dflt          = a.sign & (a.norm | a.inf);
      r.expnt_add1  = c.dbl ? 13'd1023 : 13'd127;
    end
    r.srt_skip  = r.result_zero | r.result_qnan | r.result_inf;
    r.qnan_f    = {1'b1, 51'b0};
    r.qnan_sign = 1'b0;
    if (!dflt && dq)
    begin
      if (a.snan)
        {r.qnan_sign, r.qnan_f} = {a.sign, a.payload};
      else if (c.div && b.snan)
        {r.qnan_sign, r.qnan_f} = {b.sign, b.payload};
      else if (a.qnan)
        {r.qnan_sign, r.qnan_f} = {a.sign & !a.cnan, a.payload};
      else if (c.div && b.qnan)
        {r.qnan_sign, r.qnan_f} = {b.sign & !b.cnan, b.payload};
    end
    r.rm = ((srm == 3'd7) || !c.scalar) ? drm : srm;
    case (r.rm)
      RM_RTZ:  r.of_rm_lfn = 1'b1;
      RM_RDN:  r.of_rm_lfn = !r.result_sign;
      RM_RUP:  r.of_rm_lfn = r.result_sign;
      default: r.of_rm_lfn = 1'b0;
    endcase
    return r;
  endfunction

  // idx 0 zero, 1 inf, 2 snan, 3 qnan, 4 normal, 5 denormal, 6 unboxed single
  function automatic fp_word_t special_val(int idx, logic dbl, logic neg);
    fp_word_t    d;
    logic [31:0] s;
    case (idx)
      0:       {d, s} = {64'h0, 32'h0};
      1:       {d, s} = {64'h7ff0_0000_0000_0000, 32'h7f80_0000};
      2:       {d, s} = {64'h7ff0_0000_0000_0a5a, 32'h7f80_0a5a};
      3:       {d, s} = {64'h7ff8_0000_0000_0123, 32'h7fc0_0123};
      4:       {d, s} = {64'h4008_0000_0000_0000, 32'h4040_0000};
      5:       {d, s} = {64'h0000_0000_0000_1234, 32'h0000_1234};
      default: {d, s} = {64'h3ff0_0000_0000_0000, 32'h3f80_0000};
    endcase
    if (dbl)
      return d | {neg, 63'b0};
    else if (idx == 6)
      return {32'h1234_5678, s | {neg, 31'b0}};
    else
      return {32'hffff_ffff, s | {neg, 31'b0}};
  endfunction

  task automatic check_flags(input ex2_result_t got, input ex2_result_t want);
    logic [15:0] g;
    logic [15:0] w;
    g = {got.result_zero, got.result_qnan, got.result_inf, got.result_sign, got.op0_norm,
         got.op1_norm, got.nv, got.dz, got.srt_skip, got.of_rm_lfn, got.rm, got.div,
         got.sqrt, got.dbl};
    w = {want.result_zero, want.result_qnan, want.result_inf, want.result_sign,
         want.op0_norm, want.op1_norm, want.nv, want.dz, want.srt_skip, want.of_rm_lfn,
         want.rm, want.div, want.sqrt, want.dbl};
    if (g !== w)
    begin
      $display("** Error %0t: flags got %b want %b (z q i s n0 n1 nv dz skip lfn rm d s dbl)",
               $time, g, w);
      flag_errs = flag_errs + 1;
    end
  endtask

  task automatic check_expnt(input expnt_t got0, input expnt_t got1,
                             input expnt_t want0, input expnt_t want1);
    if ((got0 !== want0) || (got1 !== want1))
    begin
      $display("** Error %0t: exponent operands got %h/%h want %h/%h",
               $time, got0, got1, want0, want1);
      expnt_errs = expnt_errs + 1;
    end
  endtask

  task automatic check_nan(input frac_t got_f, input logic got_s,
                           input frac_t want_f, input logic want_s);
    if ((got_f !== want_f) || (got_s !== want_s))
    begin
      $display("** Error %0t: qnan got sign %b payload %h want sign %b payload %h",
               $time, got_s, got_f, want_s, want_f);
      nan_errs = nan_errs + 1;
    end
  endtask

  task automatic load_op(input fp_word_t s0, input fp_word_t s1, input logic is_div,
                         input logic dbl, input logic scalar, input rm_t srm,
                         input rm_t drm, input logic dq);
    @(posedge ex1_pipe_clk);
    ex1_src0         <= s0;
    ex1_src1         <= s1;
    ex1_div          <= is_div;
    ex1_sqrt         <= !is_div;
    ex1_double       <= dbl;
    ex1_scalar       <= scalar;
    ex1_static_rm    <= srm;
    vfpu_yy_xx_rm    <= drm;
    vfpu_yy_xx_dqnan <= dq;
    ex1_pipedown     <= 1'b1;
  endtask

  // inputs keep moving while the register must hold
  task automatic hold_cycles(input int n);
    logic [31:0] r;
    repeat (n)
    begin
      @(posedge ex1_pipe_clk);
      r = $random(seed);
      ex1_pipedown  <= 1'b0;
      ex1_src0      <= {$random(seed), $random(seed)};
      ex1_src1      <= {$random(seed), $random(seed)};
      ex1_static_rm <= r[2:0];
      ex1_scalar    <= r[3];
    end
  endtask

  // behavioral EX2 register
  always @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      exp_result <= '0;
    else if (ex1_pipedown)
      exp_result <= ref_prepare(ex1_src0, ex1_src1,
                                {ex1_div, ex1_sqrt, ex1_double, ex1_scalar},
                                ex1_static_rm, vfpu_yy_xx_rm, vfpu_yy_xx_dqnan);
  end

  always @(negedge ex1_pipe_clk)
  begin
    if (cpurst_b)
    begin
      check_flags(ex2_result, exp_result);
      check_expnt(ex2_result.expnt_add0, ex2_result.expnt_add1,
                  exp_result.expnt_add0, exp_result.expnt_add1);
      check_nan(ex2_result.qnan_f, ex2_result.qnan_sign,
                exp_result.qnan_f, exp_result.qnan_sign);
    end
  end

  always @(posedge ex1_pipe_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES)
    begin
      $display("timeout: stimulus still running after %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial
  begin
    ex1_src0         <= '0;
    ex1_src1         <= '0;
    ex1_div          <= 1'b0;
    ex1_sqrt         <= 1'b0;
    ex1_double       <= 1'b0;
    ex1_scalar       <= 1'b0;
    ex1_static_rm    <= '0;
    vfpu_yy_xx_rm    <= '0;
    vfpu_yy_xx_dqnan <= 1'b0;
    ex1_pipedown     <= 1'b0;
    wait (cpurst_b === 1'b1);
    // nothing loaded yet, so the register must read all zero
    hold_cycles(2);
    // every class pair, both formats, div and sqrt, scalar low and high
    for (int d = 0; d < 2; d++)
      for (int op = 0; op < 2; op++)
        for (int sc = 0; sc < 2; sc++)
          for (int i = 0; i < 7; i++)
            for (int j = 0; j < 7; j++)
            begin
              rnd  = $random(seed);
              op_b = special_val(j, d[0], rnd[1]);
              // divisor NaN payloads differ from the dividend ones
              if ((j == 2) || (j == 3))
                op_b[4] = ~op_b[4];
              // for sqrt, j sweeps the sign of op0
              // same-class pairs always run with dqnan on
              load_op(special_val(i, d[0], (op == 1) ? j[0] : rnd[0]),
                      op_b, op == 0, d[0], sc[0],
                      rnd[4:2], rnd[7:5], rnd[8] | (i == j));
            end
    // rounding choice and largest-finite flag for every mode and sign
    for (int s = 0; s < 8; s++)
      for (int m = 0; m < 8; m++)
        for (int sc = 0; sc < 2; sc++)
          for (int sg = 0; sg < 2; sg++)
            load_op(special_val(4, 1'b1, sg[0]), special_val(4, 1'b1, 1'b0), 1'b1, 1'b1,
                    sc[0], s[2:0], m[2:0], 1'b0);
    for (int n = 0; n < 200; n++)
    begin
      rnd  = $random(seed);
      op_a = rnd[0] ? {$random(seed), $random(seed)}
                    : special_val($unsigned($random(seed)) % 7, rnd[2], rnd[3]);
      op_b = rnd[1] ? {$random(seed), $random(seed)}
                    : special_val($unsigned($random(seed)) % 7, rnd[2], rnd[4]);
      load_op(op_a, op_b, rnd[5], rnd[2], rnd[6], rnd[9:7], rnd[12:10], rnd[13]);
      hold_cycles(int'(rnd[15:14]));
    end
    hold_cycles(2);
    @(negedge ex1_pipe_clk);
    // let the last compare finish first
    #1;
    $display("errors: flags %0d, exponents %0d, nan %0d", flag_errs, expnt_errs, nan_errs);
    if ((flag_errs + expnt_errs + nan_errs) == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
// clock and reset source for the testbench
// 10 ns period, reset held low for the first 4 rising edges
`timescale 1ns/1ps

module tb_clk_gen
(
  output logic ex1_pipe_clk,
  output logic cpurst_b
);

  initial
  begin
    ex1_pipe_clk = 1'b0;
    forever #5 ex1_pipe_clk = ~ex1_pipe_clk;
  end

  initial
  begin
    cpurst_b <= 1'b0;
    repeat (4) @(posedge ex1_pipe_clk);
    cpurst_b <= 1'b1;
  end

endmodule

//--- vfdsu_prepare.sv
// EX1 operand preparation for the divide/sqrt unit, one cycle to ex2_result
// ex1_pipe_clk is free running; ex1_pipedown is the only load control
`timescale 1ns/1ps

module vfdsu_prepare
  import vfdsu_pkg::*;
(
  input  logic        ex1_pipe_clk,
  input  logic        cpurst_b,
  input  fp_word_t    ex1_src0,
  input  fp_word_t    ex1_src1,
  input  logic        ex1_div,
  input  logic        ex1_sqrt,
  input  logic        ex1_double,
  input  logic        ex1_scalar,
  input  rm_t         ex1_static_rm,
  input  rm_t         vfpu_yy_xx_rm,
  input  logic        vfpu_yy_xx_dqnan,
  input  logic        ex1_pipedown,
  output ex2_result_t ex2_result
);

  ex1_ctrl_t   ex1_ctrl;
  op_class_t   op0_class;
  op_class_t   op1_class;
  ex2_result_t ex1_result;
  logic        result_sign;
  logic        default_qnan;

  assign ex1_ctrl.div    = ex1_div;
  assign ex1_ctrl.sqrt   = ex1_sqrt;
  assign ex1_ctrl.dbl    = ex1_double;
  assign ex1_ctrl.scalar = ex1_scalar;

  // operand classification
  vfdsu_op_classify u_op0_class (
    .oper (ex1_src0),
    .ctrl (ex1_ctrl),
    .cls  (op0_class)
  );

  vfdsu_op_classify u_op1_class (
    .oper (ex1_src1),
    .ctrl (ex1_ctrl),
    .cls  (op1_class)
  );

  vfdsu_special_detect u_special (
    .ctrl         (ex1_ctrl),
    .op0          (op0_class),
    .op1          (op1_class),
    .result_sign  (result_sign),
    .nv           (ex1_result.nv),
    .dz           (ex1_result.dz),
    .result_zero  (ex1_result.result_zero),
    .result_inf   (ex1_result.result_inf),
    .result_qnan  (ex1_result.result_qnan),
    .srt_skip     (ex1_result.srt_skip),
    .default_qnan (default_qnan)
  );

  vfdsu_nan_select u_nan (
    .ctrl         (ex1_ctrl),
    .op0          (op0_class),
    .op1          (op1_class),
    .default_qnan (default_qnan),
    .dqnan_en     (vfpu_yy_xx_dqnan),
    .qnan_f       (ex1_result.qnan_f),
    .qnan_sign    (ex1_result.qnan_sign)
  );

  vfdsu_expnt_round u_expnt (
    .ctrl        (ex1_ctrl),
    .op0         (op0_class),
    .op1         (op1_class),
    .static_rm   (ex1_static_rm),
    .dyn_rm      (vfpu_yy_xx_rm),
    .result_sign (result_sign),
    .expnt_add0  (ex1_result.expnt_add0),
    .expnt_add1  (ex1_result.expnt_add1),
    .rm          (ex1_result.rm),
    .of_rm_lfn   (ex1_result.of_rm_lfn)
  );

  // remaining fields straight from control and classes
  assign ex1_result.result_sign = result_sign;
  assign ex1_result.op0_norm    = op0_class.norm;
  assign ex1_result.op1_norm    = op1_class.norm;
  assign ex1_result.div         = ex1_ctrl.div;
  assign ex1_result.sqrt        = ex1_ctrl.sqrt;
  assign ex1_result.dbl         = ex1_ctrl.dbl;

  vfdsu_ex2_pipe u_pipe (
    .ex1_pipe_clk (ex1_pipe_clk),
    .cpurst_b     (cpurst_b),
    .ex1_pipedown (ex1_pipedown),
    .ex1_result   (ex1_result),
    .ex2_result   (ex2_result)
  );

endmodule

//--- vfdsu_ex2_pipe.sv
// EX2 register, loads on ex1_pipedown and holds otherwise
// reset clears every field, payload included
`timescale 1ns/1ps

module vfdsu_ex2_pipe
  import vfdsu_pkg::*;
(
  input  logic        ex1_pipe_clk,
  input  logic        cpurst_b,
  input  logic        ex1_pipedown,
  input  ex2_result_t ex1_result,
  output ex2_result_t ex2_result
);

  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex2_result <= '0;
    end
    else if (ex1_pipedown)
    begin
      ex2_result <= ex1_result;
    end
  end

endmodule

//--- vfdsu_expnt_round.sv
// exponent adder operands, rounding mode and overflow-to-largest-finite flag
// a denormal contributes its raw exponent field, which is zero
`timescale 1ns/1ps

module vfdsu_expnt_round
  import vfdsu_pkg::*;
(
  input  ex1_ctrl_t ctrl,
  input  op_class_t op0,
  input  op_class_t op1,
  input  rm_t       static_rm,
  input  rm_t       dyn_rm,
  input  logic      result_sign,
  output expnt_t    expnt_add0,
  output expnt_t    expnt_add1,
  output rm_t       rm,
  output logic      of_rm_lfn
);

  assign expnt_add0 = op0.expnt;

  // divisor exponent for div, bias for sqrt
  always_comb
  begin
    case ({ctrl.div, ctrl.sqrt})
      2'b10:   expnt_add1 = op1.expnt;
      2'b01:   expnt_add1 = ctrl.dbl ? DBL_BIAS : SGL_BIAS;
      default: expnt_add1 = '0;
    endcase
  end

  // vector ops always use the dynamic mode
  assign rm = ((static_rm == RM_DYN) || !ctrl.scalar) ? dyn_rm : static_rm;

  // on overflow, modes that round toward zero magnitude stop at the largest finite
  always_comb
  begin
    case (rm)
      RM_RNE:  of_rm_lfn = 1'b0;
      RM_RTZ:  of_rm_lfn = 1'b1;
      RM_RDN:  of_rm_lfn = ~result_sign;
      RM_RUP:  of_rm_lfn = result_sign;
      RM_RMM:  of_rm_lfn = 1'b0;
      default: of_rm_lfn = 1'b0;
    endcase
  end

endmodule

//--- vfdsu_nan_select.sv
// picks the qNaN payload and sign, sNaN before qNaN, op0 before op1
// op1 only takes part for division
`timescale 1ns/1ps

module vfdsu_nan_select
  import vfdsu_pkg::*;
(
  input  ex1_ctrl_t ctrl,
  input  op_class_t op0,
  input  op_class_t op1,
  input  logic      default_qnan,
  input  logic      dqnan_en,
  output frac_t     qnan_f,
  output logic      qnan_sign
);

  localparam frac_t CANON_F = {1'b1, 51'b0};

  logic op1_snan_hit;
  logic op1_qnan_hit;

  assign op1_snan_hit = op1.snan & ctrl.div;
  assign op1_qnan_hit = op1.qnan & ctrl.div;

  always_comb
  begin
    qnan_f    = CANON_F;
    qnan_sign = 1'b0;
    if (default_qnan)
    begin
      qnan_f    = CANON_F;
      qnan_sign = 1'b0;
    end
    else if (dqnan_en)
    begin
      if (op0.snan)
      begin
        qnan_f    = op0.payload;
        qnan_sign = op0.sign;
      end
      else if (op1_snan_hit)
      begin
        qnan_f    = op1.payload;
        qnan_sign = op1.sign;
      end
      // a cNaN propagates as positive
      else if (op0.qnan)
      begin
        qnan_f    = op0.payload;
        qnan_sign = op0.sign & ~op0.cnan;
      end
      else if (op1_qnan_hit)
      begin
        qnan_f    = op1.payload;
        qnan_sign = op1.sign & ~op1.cnan;
      end
    end
  end

endmodule

//--- vfdsu_special_detect.sv
// special operand cases for div and sqrt: exceptions and forced results
// purely combinational
`timescale 1ns/1ps

module vfdsu_special_detect
  import vfdsu_pkg::*;
(
  input  ex1_ctrl_t ctrl,
  input  op_class_t op0,
  input  op_class_t op1,
  output logic      result_sign,
  output logic      nv,
  output logic      dz,
  output logic      result_zero,
  output logic      result_inf,
  output logic      result_qnan,
  output logic      srt_skip,
  output logic      default_qnan
);

  logic div_nv;
  logic sqrt_nv;
  logic div_zero;
  logic div_inf;
  logic div_qnan;
  logic sqrt_inf;
  logic zero_by_zero;
  logic inf_by_inf;
  logic sqrt_neg;

  assign result_sign = ctrl.div ? (op0.sign ^ op1.sign) : op0.sign;

  assign zero_by_zero = op0.zero & op1.zero;
  assign inf_by_inf   = op0.inf & op1.inf;
  // negative nonzero operand, including -inf
  assign sqrt_neg     = op0.sign & (op0.norm | op0.inf);

  // invalid operation
  assign div_nv  = op0.snan | op1.snan | zero_by_zero | inf_by_inf;
  assign sqrt_nv = op0.snan | sqrt_neg;
  assign nv      = (ctrl.div & div_nv) | (ctrl.sqrt & sqrt_nv);

  // divide by zero only for a normal dividend
  assign dz = ctrl.div & op1.zero & op0.norm;

  // zero result: 0/x, or finite over inf
  assign div_zero    = (op0.zero & op1.norm) | (~op0.expnt_max & ~op0.cnan & op1.inf);
  assign result_zero = (ctrl.div & div_zero) | (ctrl.sqrt & op0.zero);

  // inf result
  assign div_inf    = op0.inf & ~op1.expnt_max & ~op1.cnan;
  assign sqrt_inf   = op0.inf & ~op0.sign;
  assign result_inf = (ctrl.div & div_inf) | (ctrl.sqrt & sqrt_inf) | dz;

  // qNaN result, any invalid case included
  assign div_qnan    = op0.qnan | op1.qnan;
  assign result_qnan = (ctrl.div & div_qnan) | (ctrl.sqrt & op0.qnan) | nv;

  // these cases never carry an input payload
  assign default_qnan = (ctrl.div & (zero_by_zero | inf_by_inf)) | (ctrl.sqrt & sqrt_neg);

  assign srt_skip = result_zero | result_qnan | result_inf;

endmodule

//--- vfdsu_op_classify.sv
// classifies one operand; a scalar single operand without NaN boxing is a cNaN
// denormals count as normal operands, no normalization is done here
`timescale 1ns/1ps

module vfdsu_op_classify
  import vfdsu_pkg::*;
(
  input  fp_word_t  oper,
  input  ex1_ctrl_t ctrl,
  output op_class_t cls
);

  logic   exp_max;
  logic   exp_zero;
  logic   frac_zero;
  logic   frac_msb;
  logic   high_all1;
  logic   cnan;
  expnt_t exp_field;

  // field extraction by format
  assign exp_max   = ctrl.dbl ? (&oper[DBL_EXP_MSB:DBL_EXP_LSB])
                              : (&oper[SGL_EXP_MSB:SGL_EXP_LSB]);
  assign exp_zero  = ctrl.dbl ? ~(|oper[DBL_EXP_MSB:DBL_EXP_LSB])
                              : ~(|oper[SGL_EXP_MSB:SGL_EXP_LSB]);
  assign frac_zero = ctrl.dbl ? ~(|oper[DBL_FRAC_W-1:0])
                              : ~(|oper[SGL_FRAC_W-1:0]);
  assign frac_msb  = ctrl.dbl ? oper[DBL_FRAC_W-1] : oper[SGL_FRAC_W-1];
  assign exp_field = ctrl.dbl ? {2'b0, oper[DBL_EXP_MSB:DBL_EXP_LSB]}
                              : {5'b0, oper[SGL_EXP_MSB:SGL_EXP_LSB]};

  // NaN boxing check
  assign high_all1 = &oper[63:32];
  assign cnan      = ctrl.scalar & ~ctrl.dbl & ~high_all1;

  assign cls.sign      = ctrl.dbl ? oper[63] : oper[31];
  assign cls.cnan      = cnan;
  assign cls.zero      = exp_zero & frac_zero & ~cnan;
  assign cls.inf       = exp_max & frac_zero & ~cnan;
  // normal, or denormal treated as normal
  assign cls.norm      = ~exp_max & ~cnan & (~exp_zero | ~frac_zero);
  assign cls.snan      = exp_max & ~frac_zero & ~frac_msb & ~cnan;
  assign cls.qnan      = (exp_max & frac_msb) | cnan;
  assign cls.expnt_max = exp_max;
  assign cls.expnt     = exp_field;
  // raw low bits as payload, cleared for a cNaN
  assign cls.payload   = cnan ? '0 : oper[DBL_FRAC_W-1:0];

endmodule

//--- vfdsu_pkg.sv
// shared types and constants for the divide/sqrt EX1 operand stage
// only double and single precision; single operands sit in bits [31:0]
package vfdsu_pkg;

  // raw operand and meaningful widths
  typedef logic [63:0] fp_word_t;
  typedef logic [12:0] expnt_t;
  typedef logic [51:0] frac_t;
  typedef logic [2:0]  rm_t;

  // field positions
  localparam int DBL_EXP_MSB = 62;
  localparam int DBL_EXP_LSB = 52;
  localparam int SGL_EXP_MSB = 30;
  localparam int SGL_EXP_LSB = 23;
  localparam int DBL_FRAC_W  = 52;
  localparam int SGL_FRAC_W  = 23;

  // exponent biases, used as the sqrt second adder operand
  localparam expnt_t DBL_BIAS = 13'd1023;
  localparam expnt_t SGL_BIAS = 13'd127;

  // rounding mode codes
  localparam rm_t RM_RNE = 3'd0;
  localparam rm_t RM_RTZ = 3'd1;
  localparam rm_t RM_RDN = 3'd2;
  localparam rm_t RM_RUP = 3'd3;
  localparam rm_t RM_RMM = 3'd4;
  // static field value that defers to the dynamic mode
  localparam rm_t RM_DYN = 3'd7;

  // operation control, single precision when dbl is low
  typedef struct packed {
    logic div;
    logic sqrt;
    logic dbl;
    logic scalar;
  } ex1_ctrl_t;

  // per-operand classification
  typedef struct packed {
    logic   sign;
    logic   cnan;
    logic   zero;
    logic   inf;
    logic   norm;
    logic   snan;
    logic   qnan;
    logic   expnt_max;
    expnt_t expnt;
    frac_t  payload;
  } op_class_t;

  // everything handed to EX2
  typedef struct packed {
    logic   result_zero;
    logic   result_qnan;
    logic   result_inf;
    logic   result_sign;
    logic   op0_norm;
    logic   op1_norm;
    expnt_t expnt_add0;
    expnt_t expnt_add1;
    logic   nv;
    logic   dz;
    logic   srt_skip;
    logic   of_rm_lfn;
    logic   qnan_sign;
    frac_t  qnan_f;
    rm_t    rm;
    logic   div;
    logic   sqrt;
    logic   dbl;
  } ex2_result_t;

endpackage
